// ==== source/ram_check_pkg.sv ====
`default_nettype none

package ram_check_pkg;

    // ########################################
    // Memory geometry
    // ########################################

    localparam int addr_width = 5;                 // 32-entry LUT memory.
    localparam int data_width = 6;
    localparam int max_address = 31;              // Last address tested.

    // ########################################
    // Test phases and frame codes
    // ########################################

    // Phase values are printable so they read directly off the serial line.
    typedef enum logic [7:0] {
        phase_write_pattern  = 8'h41,             // 'A'.
        phase_verify_pattern = 8'h42,             // 'B'.
        phase_write_inverse  = 8'h43,             // 'C'.
        phase_verify_inverse = 8'h44              // 'D'.
    } test_phase_t;

    localparam logic [7:0] frame_error_code = 8'h45;   // 'E'.
    localparam logic [7:0] frame_loop_code = 8'h4c;    // 'L'.

    // Address-derived pattern; top bit toggles between neighbours.
    function automatic logic [data_width-1:0] rom_pattern(
        input logic [addr_width-1:0] address
    );
        return {~address[0], address};
    endfunction

endpackage

`default_nettype wire

// ==== source/lut_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lut_ram
    import ram_check_pkg::*;
(
    input  logic                  clk,
    input  logic                  write_enable,
    input  logic [addr_width-1:0] write_address,
    input  logic [addr_width-1:0] read_address,
    input  logic [data_width-1:0] write_data,
    input  logic                  upset_strobe,
    input  logic [addr_width-1:0] upset_address,
    input  logic [2:0]            upset_bit,
    output logic [data_width-1:0] read_data
);

    logic [data_width-1:0] mem [2**addr_width];
    logic [data_width-1:0] flip_mask;

    // Bits above the word width give an empty mask.
    always_comb begin
        flip_mask = '0;
        if (upset_bit < data_width) begin
            flip_mask = data_width'(1) << upset_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (upset_strobe) begin
            mem[upset_address] <= mem[upset_address] ^ flip_mask;
        end
        if (write_enable) begin
            mem[write_address] <= write_data;   // Last assignment wins over an upset.
        end
    end

    assign read_data = mem[read_address];     // Asynchronous LUT read.

endmodule

`default_nettype wire

// ==== source/ram_march_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_march_tester
    import ram_check_pkg::*;
#(
    parameter int max_address = ram_check_pkg::max_address
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] read_data,
    input  logic                  busy,
    output logic [addr_width-1:0] write_address,
    output logic [addr_width-1:0] read_address,
    output logic [data_width-1:0] write_data,
    output logic                  write_enable,
    output logic                  loop_complete,
    output logic                  error,
    output test_phase_t           error_state,
    output logic [addr_width-1:0] error_address,
    output logic [data_width-1:0] expected_data,
    output logic [data_width-1:0] actual_data
);

    localparam logic [addr_width-1:0] last_address = addr_width'(max_address);

    test_phase_t           phase;
    test_phase_t           next_phase;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] expected_word;
    logic                  inverse_phase;
    logic                  write_phase;
    logic                  verify_phase;
    logic                  mismatch;
    logic                  last_step;
    logic                  loop_dirty;

    // ########################################
    // Pattern and compare
    // ########################################

    assign inverse_phase = (phase == phase_write_inverse) || (phase == phase_verify_inverse);
    assign write_phase = (phase == phase_write_pattern) || (phase == phase_write_inverse);
    assign verify_phase = !write_phase;

    always_comb begin
        expected_word = rom_pattern(address);
        if (inverse_phase) begin
            expected_word = ~expected_word;
        end
    end

    assign read_address = address;
    assign mismatch = verify_phase && (read_data != expected_word);
    assign last_step = !busy && (phase == phase_verify_inverse) && (address == last_address);

    always_comb begin
        case (phase)
            phase_write_pattern:  next_phase = phase_verify_pattern;
            phase_verify_pattern: next_phase = phase_write_inverse;
            phase_write_inverse:  next_phase = phase_verify_inverse;
            default:              next_phase = phase_write_pattern;
        endcase
    end

    // ########################################
    // Sequencer
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phase_write_pattern;
            address <= '0;
            write_enable <= 1'b0;
            loop_complete <= 1'b0;
            error <= 1'b0;
            loop_dirty <= 1'b0;
        end else begin
            write_enable <= write_phase && !busy;
            error <= mismatch && !busy;
            // Only loops without a mismatch report completion.
            loop_complete <= last_step && !loop_dirty && !mismatch;
            if (!busy) begin                          // Stall holds phase and address.
                if (address == last_address) begin
                    address <= '0;
                    phase <= next_phase;
                end else begin
                    address <= address + 1'b1;
                end
                if (last_step) begin
                    loop_dirty <= 1'b0;
                end else if (mismatch) begin
                    loop_dirty <= 1'b1;
                end
            end
        end
    end

    // Write port lags the counter by one cycle.
    always_ff @(posedge clk) begin
        write_address <= address;
        write_data <= expected_word;
    end

    // Mismatch detail, held until the next error.
    always_ff @(posedge clk) begin
        if (mismatch && !busy) begin
            error_state <= phase;
            error_address <= address;
            expected_data <= expected_word;
            actual_data <= read_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/error_reporter.sv ====
`timescale 1ns/1ps
`default_nettype none

module error_reporter
    import ram_check_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  loop_complete,
    input  logic                  error,
    input  test_phase_t           error_state,
    input  logic [addr_width-1:0] error_address,
    input  logic [data_width-1:0] expected_data,
    input  logic [data_width-1:0] actual_data,
    input  logic                  tx_accepted,
    output logic                  tx_valid,
    output logic [7:0]            tx_byte,
    output logic                  busy
);

    localparam int frame_bytes = 5;

    logic [7:0] frame [frame_bytes];
    logic [2:0] byte_index;
    logic [2:0] last_index;

    // ########################################
    // Frame sequencing
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            byte_index <= '0;
            last_index <= '0;
        end else if (!busy) begin
            byte_index <= '0;
            if (error) begin                          // Error wins over loop marker.
                busy <= 1'b1;
                last_index <= 3'(frame_bytes - 1);
            end else if (loop_complete) begin
                busy <= 1'b1;
                last_index <= '0;
            end
        end else if (tx_accepted) begin
            if (byte_index == last_index) begin
                busy <= 1'b0;
            end else begin
                byte_index <= byte_index + 1'b1;
            end
        end
    end

    // Snapshot of the fields; the tester may overwrite them while sending.
    always_ff @(posedge clk) begin
        if (!busy) begin
            if (error) begin
                frame[0] <= frame_error_code;
                frame[1] <= error_state;
                frame[2] <= 8'(error_address);
                frame[3] <= 8'(expected_data);
                frame[4] <= 8'(actual_data);
            end else if (loop_complete) begin
                frame[0] <= frame_loop_code;
            end
        end
    end

    assign tx_valid = busy;
    assign tx_byte = frame[byte_index];

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 25
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_accepted,
    output logic       tx
);

    localparam int baud_width = $clog2(clks_per_bit + 1);
    localparam logic [baud_width-1:0] baud_last = baud_width'(clks_per_bit - 1);

    logic [9:0]            shift;                 // Stop, data LSB first, start.
    logic [3:0]            bit_count;
    logic [baud_width-1:0] baud_count;
    logic                  active;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            tx_accepted <= 1'b0;
            bit_count <= '0;
            baud_count <= '0;
            tx <= 1'b1;                           // Line idles high.
        end else begin
            tx_accepted <= 1'b0;
            if (!active) begin
                tx <= 1'b1;
                if (tx_valid) begin
                    active <= 1'b1;
                    tx_accepted <= 1'b1;
                    bit_count <= '0;
                    baud_count <= '0;
                end
            end else begin
                tx <= shift[0];
                if (baud_count == baud_last) begin
                    baud_count <= '0;
                    if (bit_count == 4'd9) begin
                        active <= 1'b0;           // Stop bit done.
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end else begin
                    baud_count <= baud_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && tx_valid) begin
            shift <= {1'b1, tx_byte, 1'b0};
        end else if (active && baud_count == baud_last) begin
            shift <= {1'b1, shift[9:1]};
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_check_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_check_top
    import ram_check_pkg::*;
#(
    parameter int clks_per_bit = 25,
    parameter int max_address = ram_check_pkg::max_address
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  upset_strobe,
    input  logic [addr_width-1:0] upset_address,
    input  logic [2:0]            upset_bit,
    output logic                  tx
);

    // Memory port.
    logic [addr_width-1:0] write_address;
    logic [addr_width-1:0] read_address;
    logic [data_width-1:0] write_data;
    logic [data_width-1:0] read_data;
    logic                  write_enable;

    // Reporting.
    logic                  loop_complete;
    logic                  error;
    test_phase_t           error_state;
    logic [addr_width-1:0] error_address;
    logic [data_width-1:0] expected_data;
    logic [data_width-1:0] actual_data;
    logic                  busy;

    // Byte stream to the UART.
    logic                  tx_valid;
    logic                  tx_accepted;
    logic [7:0]            tx_byte;

    lut_ram ram (
        .clk           (clk),
        .write_enable  (write_enable),
        .write_address (write_address),
        .read_address  (read_address),
        .write_data    (write_data),
        .upset_strobe  (upset_strobe),
        .upset_address (upset_address),
        .upset_bit     (upset_bit),
        .read_data     (read_data)
    );

    ram_march_tester #(
        .max_address (max_address)
    ) tester (
        .clk           (clk),
        .reset         (reset),
        .read_data     (read_data),
        .busy          (busy),
        .write_address (write_address),
        .read_address  (read_address),
        .write_data    (write_data),
        .write_enable  (write_enable),
        .loop_complete (loop_complete),
        .error         (error),
        .error_state   (error_state),
        .error_address (error_address),
        .expected_data (expected_data),
        .actual_data   (actual_data)
    );

    error_reporter reporter (
        .clk           (clk),
        .reset         (reset),
        .loop_complete (loop_complete),
        .error         (error),
        .error_state   (error_state),
        .error_address (error_address),
        .expected_data (expected_data),
        .actual_data   (actual_data),
        .tx_accepted   (tx_accepted),
        .tx_valid      (tx_valid),
        .tx_byte       (tx_byte),
        .busy          (busy)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart (
        .clk         (clk),
        .reset       (reset),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_accepted (tx_accepted),
        .tx          (tx)
    );

endmodule

`default_nettype wire

// ==== verification/ram_check_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_check_tb
    import ram_check_pkg::*;
();

    localparam int clks_per_bit = 4;
    localparam int loop_cycles = 130;                 // 128 steps plus the stall for 'L'.
    localparam int clean_cycles = 1000;
    localparam int pattern_upset_delay = 40;          // Counted from the last reset edge.
    localparam int inverse_upset_offset = 80;         // Between inverse write and its verify.
    localparam int timeout_cycles = 6000;             // Eight loops and four frames, with margin.

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  upset_strobe = 1'b0;
    logic [addr_width-1:0] upset_address = '0;
    logic [2:0]            upset_bit = '0;
    logic                  tx;

    logic [7:0]  rx_bytes [$];
    string       exp_name [$];
    test_phase_t exp_phase [$];
    int          exp_address [$];
    int          exp_bit [$];

    int bytes_received = 0;
    int loops_seen = 0;
    int frames_seen = 0;
    int frames_expected = 0;
    int frames_checked = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;

    ram_check_top #(
        .clks_per_bit (clks_per_bit),
        .max_address  (max_address)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .upset_strobe  (upset_strobe),
        .upset_address (upset_address),
        .upset_bit     (upset_bit),
        .tx            (tx)
    );

    always #10 clk = ~clk;

    // ########################################
    // Reference model and helpers
    // ########################################

    // Top bit of the stored word is the inverted address LSB.
    function automatic logic [data_width-1:0] expected_word(
        input test_phase_t           phase,
        input logic [addr_width-1:0] address
    );
        logic [data_width-1:0] word;
        word = {~address[0], address};
        if (phase == phase_write_inverse || phase == phase_verify_inverse) begin
            word = ~word;
        end
        return word;
    endfunction

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        wait_cycles(5);
        reset = 1'b0;
    endtask

    task automatic pulse_upset(input int address, input int bit_index);
        upset_address = addr_width'(address);
        upset_bit = 3'(bit_index);
        upset_strobe = 1'b1;
        @(negedge clk);
        upset_strobe = 1'b0;
    endtask

    task automatic expect_frame(input string name, input test_phase_t phase,
                                input int address, input int bit_index);
        exp_name.push_back(name);
        exp_phase.push_back(phase);
        exp_address.push_back(address);
        exp_bit.push_back(bit_index);
        frames_expected++;
    endtask

    task automatic wait_frames();
        while (frames_checked < frames_expected) @(negedge clk);
    endtask

    task automatic next_byte(output logic [7:0] value);
        while (rx_bytes.size() == 0) @(posedge clk);
        value = rx_bytes.pop_front();
    endtask

    task automatic check_byte(input string name, input string field,
                              input logic [7:0] expected, input logic [7:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("Error: %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_error_frame(input logic [7:0] state_byte, input logic [7:0] address_byte,
                                     input logic [7:0] expected_byte,
                                     input logic [7:0] actual_byte);
        string                 name;
        test_phase_t           phase;
        int                    address;
        int                    bit_index;
        logic [data_width-1:0] word;
        assert (address_byte[7:6] == 2'b00 && expected_byte[7:6] == 2'b00
                && actual_byte[7:6] == 2'b00) else begin
            other_errors++;
            $display("Frame carries set bits above the address or data width");
        end
        assert ($countones(expected_byte ^ actual_byte) == 1) else begin
            other_errors++;
            $display("Frame words %h and %h do not differ in one bit", expected_byte, actual_byte);
        end
        assert (exp_name.size() > 0) else begin
            other_errors++;
            $display("A frame arrived with no upset pending");
        end
        if (exp_name.size() > 0) begin
            name = exp_name.pop_front();
            phase = exp_phase.pop_front();
            address = exp_address.pop_front();
            bit_index = exp_bit.pop_front();
            word = expected_word(phase, addr_width'(address));
            check_byte(name, "state", 8'(phase), state_byte);
            check_byte(name, "address", 8'(address), address_byte);
            check_byte(name, "expected", 8'(word), expected_byte);
            check_byte(name, "actual", 8'(word ^ (data_width'(1) << bit_index)), actual_byte);
            frames_checked++;
        end
    endtask

    task automatic report_counts();
        $display("Bytes: %0d, loop markers: %0d, frames: %0d, value errors: %0d, other errors: %0d",
                 bytes_received, loops_seen, frames_seen, value_errors, other_errors);
    endtask

    // ########################################
    // Serial decoder and byte checker
    // ########################################

    initial begin : serial_decoder
        logic [7:0] data;
        logic       start_ok;
        int         i;
        wait (!reset);
        forever begin
            @(negedge tx);
            wait_cycles(clks_per_bit / 2);            // Middle of the start bit.
            start_ok = (tx === 1'b0);
            assert (start_ok) else begin
                other_errors++;
                $display("Start bit did not hold low to its middle");
            end
            if (start_ok) begin
                for (i = 0; i < 8; i++) begin
                    wait_cycles(clks_per_bit);
                    data[i] = tx;                     // LSB first.
                end
                wait_cycles(clks_per_bit);
                assert (tx === 1'b1) else begin
                    other_errors++;
                    $display("Stop bit missing after byte %h", data);
                end
                rx_bytes.push_back(data);
                bytes_received++;
            end
        end
    end

    initial begin : byte_checker
        logic [7:0] value;
        logic [7:0] state_byte;
        logic [7:0] address_byte;
        logic [7:0] expected_byte;
        logic [7:0] actual_byte;
        forever begin
            next_byte(value);
            assert (value == frame_loop_code || value == frame_error_code) else begin
                other_errors++;
                $display("Byte %h is neither a loop marker nor a frame start", value);
            end
            if (value == frame_loop_code) begin
                loops_seen++;
            end else if (value == frame_error_code) begin
                next_byte(state_byte);
                next_byte(address_byte);
                next_byte(expected_byte);
                next_byte(actual_byte);
                frames_seen++;
                check_error_frame(state_byte, address_byte, expected_byte, actual_byte);
            end
        end
    end

    // ########################################
    // Stimulus
    // ########################################

    initial begin : stimulus
        int address;
        int bit_index;
        int clean_loops;
        int loops_before;
        void'($urandom(32'h3a2d));
        apply_reset();

        // No upsets, only loop markers.
        wait_cycles(clean_cycles);
        clean_loops = loops_seen;
        assert (clean_loops >= 6) else begin
            value_errors++;
            $display("Error: clean_loops expected at least 6 actual %0d", clean_loops);
        end

        // Written but not yet verified in the first pattern pass.
        apply_reset();
        address = $urandom_range(max_address, 8);
        bit_index = $urandom_range(data_width - 1, 0);
        wait_cycles(pattern_upset_delay - 1);
        expect_frame("pattern_verify", phase_verify_pattern, address, bit_index);
        pulse_upset(address, bit_index);
        wait_frames();

        address = $urandom_range(max_address, 8);
        bit_index = $urandom_range(data_width - 1, 0);
        @(negedge tx);                                // Start of the next 'L' marker.
        wait_cycles(inverse_upset_offset + address);
        expect_frame("inverse_verify", phase_verify_inverse, address, bit_index);
        pulse_upset(address, bit_index);
        wait_frames();

        // Lands before the pattern write of that address, so no frame.
        address = $urandom_range(max_address, 8);
        bit_index = $urandom_range(data_width - 1, 0);
        @(negedge tx);
        loops_before = loops_seen;
        wait_cycles(address - 4);
        pulse_upset(address, bit_index);
        wait_cycles(3 * loop_cycles);
        assert (loops_seen - loops_before >= 3) else begin
            value_errors++;
            $display("Error: write_repair loop markers expected 3 actual %0d",
                     loops_seen - loops_before);
        end

        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            report_counts();
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== ram_check.f ====
source/ram_check_pkg.sv
source/lut_ram.sv
source/ram_march_tester.sv
source/error_reporter.sv
source/uart_tx.sv
source/ram_check_top.sv
verification/ram_check_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RAM check testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ram_check_tb \
    -f ram_check.f \
    -o ram_check_sim

./obj_dir/ram_check_sim | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
